// ==== design/outlierPkg.sv ====
package outlierPkg;

    // lane geometry
    localparam int Dimm = 16;
    localparam int NumLr = 4;
    localparam int IndexWidth = 4;
    // 0 to 16 outliers
    localparam int CountWidth = 5;
    // one stride stage per index bit
    localparam int StageCount = 4;

    // word addresses, mask write shares word 0
    localparam logic [1:0] AddrStatus = 2'd0;
    localparam logic [1:0] AddrResult = 2'd1;

    // lane position plus outlier flag
    typedef struct packed {
        logic [IndexWidth-1:0] index;
        logic                  flag;
    } laneT;

    typedef laneT [Dimm-1:0] laneVecT;

    // one mask travelling through the network
    typedef struct packed {
        logic                  valid;
        laneVecT               lanes;
        logic [CountWidth-1:0] count;
    } flightT;

    // queue entry, slot 0 is the lowest outlier lane
    typedef struct packed {
        logic [CountWidth-1:0]                count;
        logic [NumLr-1:0][IndexWidth-1:0]     slot;
    } resultT;

    // wishbone classic master side
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;
        logic [31:0] dat;
    } wbReqT;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wbRspT;

    // same read word, decoded by address
    typedef union packed {
        struct packed {
            logic [26:0] pad;
            logic [2:0]  level;
            logic        full;
            logic        empty;
        } statusView;
        struct packed {
            logic [31-CountWidth-NumLr*IndexWidth:0] pad;
            resultT                                  result;
        } resultView;
    } readWordU;

endpackage

// ==== design/maskWriteSlave.sv ====
`timescale 1ns/1ps

module maskWriteSlave (
    input  logic               clk,
    input  logic               rstN,
    input  outlierPkg::wbReqT  req,
    input  logic               creditReady,
    output logic               ack,
    output outlierPkg::flightT launch
);

    logic writeHit;
    logic accept;
    logic [outlierPkg::Dimm-1:0] mask;
    logic [outlierPkg::CountWidth-1:0] popCount;
    outlierPkg::laneVecT laneNext;

    logic launchValid;
    outlierPkg::laneVecT launchLanes;
    logic [outlierPkg::CountWidth-1:0] launchCount;

    // only writes to word 0 carry a mask
    assign writeHit = req.cyc && req.stb && req.we && (req.adr == outlierPkg::AddrStatus);
    // hold off while the queue has no room, single ack per cycle
    assign accept = writeHit && !ack && creditReady;
    assign mask = req.dat[outlierPkg::Dimm-1:0];

    // each lane tagged with its own position
    always_comb begin
        popCount = '0;
        for (int i = 0; i < outlierPkg::Dimm; i++) begin
            laneNext[i].index = i[outlierPkg::IndexWidth-1:0];
            laneNext[i].flag = mask[i];
            popCount = popCount + {{(outlierPkg::CountWidth-1){1'b0}}, mask[i]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ack <= 1'b0;
            launchValid <= 1'b0;
        end else begin
            ack <= accept;
            // launch one cycle after the ack
            launchValid <= ack;
        end
    end

    // master still holds dat while ack is up
    always_ff @(posedge clk) begin
        if (ack) begin
            launchLanes <= laneNext;
            launchCount <= popCount;
        end
    end

    assign launch = '{valid: launchValid, lanes: launchLanes, count: launchCount};

    // ack only answers a live strobe
    assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) |-> $past(req.cyc && req.stb));
    // no back-to-back acks
    assert property (@(posedge clk) disable iff (!rstN) ack |=> !ack);

endmodule

// ==== design/strideStage.sv ====
`timescale 1ns/1ps

module strideStage #(
    parameter int Shift = 1
) (
    input  logic               clk,
    input  logic               rstN,
    input  outlierPkg::flightT stageIn,
    output outlierPkg::flightT stageOut
);

    // count bit that selects a move of Shift lanes
    localparam int SelBit = $clog2(Shift);

    // non-outliers below each lane
    logic [outlierPkg::Dimm-1:0][outlierPkg::IndexWidth-1:0] gapCount;
    outlierPkg::laneVecT moved;

    logic outValid;
    outlierPkg::laneVecT outLanes;
    logic [outlierPkg::CountWidth-1:0] outCount;

    // running prefix count of empty lanes
    always_comb begin : prefixCount
        logic [outlierPkg::IndexWidth-1:0] run;
        run = '0;
        for (int i = 0; i < outlierPkg::Dimm; i++) begin
            gapCount[i] = run;
            run = run + {{(outlierPkg::IndexWidth-1){1'b0}}, !stageIn.lanes[i].flag};
        end
    end

    // earlier stages cleared the lower count bits, so moves never collide
    for (genvar i = 0; i < outlierPkg::Dimm; i++) begin : laneMux
        if (i + Shift < outlierPkg::Dimm) begin : withSource
            // upper outlier sliding in wins the slot
            assign moved[i] =
                (stageIn.lanes[i+Shift].flag && gapCount[i+Shift][SelBit]) ?
                    stageIn.lanes[i+Shift] :
                (stageIn.lanes[i].flag && !gapCount[i][SelBit]) ?
                    stageIn.lanes[i] : '0;
        end else begin : tailLane
            // top lanes have nothing above them
            assign moved[i] = (stageIn.lanes[i].flag && !gapCount[i][SelBit]) ?
                stageIn.lanes[i] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= stageIn.valid;
        end
    end

    // lane data and count follow valid
    always_ff @(posedge clk) begin
        outLanes <= moved;
        outCount <= stageIn.count;
    end

    assign stageOut = '{valid: outValid, lanes: outLanes, count: outCount};

endmodule

// ==== design/compactNet.sv ====
`timescale 1ns/1ps

module compactNet (
    input  logic               clk,
    input  logic               rstN,
    input  outlierPkg::flightT netIn,
    output outlierPkg::flightT netOut,
    output logic [2:0]         inFlight
);

    // tap 0 is the launch word, last tap is the output
    outlierPkg::flightT stageBus [outlierPkg::StageCount+1];
    logic [outlierPkg::Dimm-1:0] outFlags;

    assign stageBus[0] = netIn;

    // strides 1, 2, 4, 8
    for (genvar j = 0; j < outlierPkg::StageCount; j++) begin : stride
        strideStage #(
            .Shift(1 << j)
        ) uStage (
            .clk     (clk),
            .rstN    (rstN),
            .stageIn (stageBus[j]),
            .stageOut(stageBus[j+1])
        );
    end

    assign netOut = stageBus[outlierPkg::StageCount];

    // launch and output taps count too, queue has not taken them yet
    always_comb begin
        inFlight = '0;
        for (int k = 0; k <= outlierPkg::StageCount; k++) begin
            inFlight = inFlight + {2'b00, stageBus[k].valid};
        end
    end

    always_comb begin
        for (int i = 0; i < outlierPkg::Dimm; i++) begin
            outFlags[i] = netOut.lanes[i].flag;
        end
    end

    // compaction loses and invents no outliers
    assert property (@(posedge clk) disable iff (!rstN)
        netOut.valid |-> ($countones(outFlags) == int'(netOut.count)));

endmodule

// ==== design/resultQueue.sv ====
`timescale 1ns/1ps

module resultQueue #(
    parameter int QueueDepth = 4
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  outlierPkg::wbReqT    req,
    input  outlierPkg::flightT   netOut,
    input  logic [2:0]           inFlight,
    output logic                 ack,
    output outlierPkg::readWordU readData,
    output logic                 creditReady
);

    localparam int PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int LevelWidth = $clog2(QueueDepth + 1);

    outlierPkg::resultT entries [QueueDepth];
    logic [PtrWidth-1:0] wrPtr;
    logic [PtrWidth-1:0] rdPtr;
    logic [LevelWidth-1:0] level;
    logic empty;
    logic full;
    logic readHit;
    logic push;
    logic pop;
    int freeCount;
    outlierPkg::resultT incoming;
    outlierPkg::readWordU readNext;

    assign empty = (level == '0);
    assign full = (level == LevelWidth'(QueueDepth));
    // any read address answers, one ack per strobe
    assign readHit = req.cyc && req.stb && !req.we && !ack;
    assign push = netOut.valid;
    // empty result read pops nothing
    assign pop = readHit && (req.adr == outlierPkg::AddrResult) && !empty;

    // room must cover every word still in the network
    assign freeCount = QueueDepth - int'(level);
    assign creditReady = freeCount > int'(inFlight);

    // keep only the leading slots of the compacted lanes
    always_comb begin
        incoming.count = netOut.count;
        for (int k = 0; k < outlierPkg::NumLr; k++) begin
            incoming.slot[k] = netOut.lanes[k].index;
        end
    end

    always_comb begin
        readNext = '0;
        if (req.adr == outlierPkg::AddrStatus) begin
            readNext.statusView.level = 3'(level);
            readNext.statusView.full = full;
            readNext.statusView.empty = empty;
        end else if (req.adr == outlierPkg::AddrResult && !empty) begin
            readNext.resultView.result = entries[rdPtr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            level <= '0;
            ack <= 1'b0;
        end else begin
            ack <= readHit;
            if (push) begin
                wrPtr <= (wrPtr == PtrWidth'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PtrWidth'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            // simultaneous push and pop keeps the level
            if (push && !pop) begin
                level <= level + 1'b1;
            end else if (pop && !push) begin
                level <= level - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= incoming;
        end
        if (readHit) begin
            readData <= readNext;
        end
    end

    // credit check upstream must prevent overflow
    assert property (@(posedge clk) disable iff (!rstN) push |-> !full);

endmodule

// ==== design/outlierSelect.sv ====
`timescale 1ns/1ps

module outlierSelect #(
    parameter int QueueDepth = 4
) (
    input  logic              clk,
    input  logic              rstN,
    input  outlierPkg::wbReqT req,
    output outlierPkg::wbRspT rsp
);

    logic creditReady;
    logic writeAck;
    logic readAck;
    logic [2:0] inFlight;
    outlierPkg::flightT launch;
    outlierPkg::flightT netOut;
    outlierPkg::readWordU readData;

    // write side, mask in
    maskWriteSlave uWrite (
        .clk        (clk),
        .rstN       (rstN),
        .req        (req),
        .creditReady(creditReady),
        .ack        (writeAck),
        .launch     (launch)
    );

    // four registered strides
    compactNet uNet (
        .clk     (clk),
        .rstN    (rstN),
        .netIn   (launch),
        .netOut  (netOut),
        .inFlight(inFlight)
    );

    // read side, results out
    resultQueue #(
        .QueueDepth(QueueDepth)
    ) uQueue (
        .clk        (clk),
        .rstN       (rstN),
        .req        (req),
        .netOut     (netOut),
        .inFlight   (inFlight),
        .ack        (readAck),
        .readData   (readData),
        .creditReady(creditReady)
    );

    // writes and reads never ack together
    assign rsp = '{ack: writeAck | readAck, dat: readAck ? readData : 32'd0};

endmodule

// ==== bench/tbVectors.svh ====
// directed table entry, mask plus its hand-worked result
typedef struct packed {
    logic [outlierPkg::Dimm-1:0] mask;
    outlierPkg::resultT          want;
} vecT;

localparam int DirectedCount = 6;

// want reads as count, then slot 3 down to slot 0
localparam vecT directed [DirectedCount] = '{
    {16'h0000, 5'd0, 4'd0, 4'd0, 4'd0, 4'd0},
    {16'hFFFF, 5'd16, 4'd3, 4'd2, 4'd1, 4'd0},
    {16'h0001, 5'd1, 4'd0, 4'd0, 4'd0, 4'd0},
    {16'h8000, 5'd1, 4'd0, 4'd0, 4'd0, 4'd15},
    {16'hAAAA, 5'd8, 4'd7, 4'd5, 4'd3, 4'd1},
    {16'hFF00, 5'd8, 4'd11, 4'd10, 4'd9, 4'd8}
};

// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsrNext(input logic [15:0] state);
    logic [15:0] next;
    next = {1'b0, state[15:1]};
    if (state[0]) begin
        next = next ^ 16'hB400;
    end
    return next;
endfunction

// count of set bits, slot k is the k-th set lane from lane 0
function automatic outlierPkg::resultT refResult(input logic [outlierPkg::Dimm-1:0] mask);
    outlierPkg::resultT r;
    int n;
    r = '0;
    n = 0;
    for (int i = 0; i < outlierPkg::Dimm; i++) begin
        if (mask[i]) begin
            if (n < outlierPkg::NumLr) begin
                r.slot[n] = outlierPkg::IndexWidth'(i);
            end
            n++;
        end
    end
    r.count = outlierPkg::CountWidth'(n);
    return r;
endfunction

// ==== bench/tbOutlierSelect.sv ====
`timescale 1ns/1ps

module tbOutlierSelect;

    localparam int QueueDepth = 4;
    localparam int RandomCount = 40;
    localparam int BurstCount = 6;

    logic clk;
    logic rstN;
    outlierPkg::wbReqT req;
    outlierPkg::wbRspT rsp;
    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;
    logic [15:0] lfsrState;

    `include "tbVectors.svh"

    // 64 cycles per mask plus the reset cycles
    localparam int CycleLimit = 64 * (DirectedCount + RandomCount + BurstCount) + 8;

    outlierSelect #(
        .QueueDepth(QueueDepth)
    ) dut (
        .clk (clk),
        .rstN(rstN),
        .req (req),
        .rsp (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CycleLimit) begin
            $display("timeout, run went past %0d cycles", CycleLimit);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic flagMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        errorCount++;
        $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, want);
    endtask

    task automatic checkResult(input string name, input outlierPkg::resultT got,
                               input outlierPkg::resultT want);
        checkCount++;
        if (got.count !== want.count) begin
            flagMismatch({name, ".count"}, 32'(got.count), 32'(want.count));
        end
        // slots past the count carry nothing
        for (int k = 0; k < outlierPkg::NumLr; k++) begin
            if (k < int'(want.count) && got.slot[k] !== want.slot[k]) begin
                flagMismatch($sformatf("%s.slot[%0d]", name, k), 32'(got.slot[k]),
                             32'(want.slot[k]));
            end
        end
    endtask

    task automatic checkStatus(input string name, input outlierPkg::readWordU got,
                               input outlierPkg::readWordU want);
        checkCount++;
        if (got.statusView.level !== want.statusView.level) begin
            flagMismatch({name, ".level"}, 32'(got.statusView.level),
                         32'(want.statusView.level));
        end
        if (got.statusView.full !== want.statusView.full) begin
            flagMismatch({name, ".full"}, 32'(got.statusView.full), 32'(want.statusView.full));
        end
        if (got.statusView.empty !== want.statusView.empty) begin
            flagMismatch({name, ".empty"}, 32'(got.statusView.empty),
                         32'(want.statusView.empty));
        end
    endtask

    task automatic checkWord(input string name, input outlierPkg::readWordU got,
                             input outlierPkg::readWordU want);
        checkCount++;
        if (got !== want) begin
            flagMismatch(name, got, want);
        end
    endtask

    function automatic outlierPkg::readWordU statusWord(input int level, input logic full,
                                                        input logic empty);
        outlierPkg::readWordU w;
        w = '0;
        w.statusView.level = 3'(level);
        w.statusView.full = full;
        w.statusView.empty = empty;
        return w;
    endfunction

    // one classic cycle, abandoned after limit clocks without ack
    task automatic busCycle(input logic isWrite, input logic [1:0] addr, input logic [31:0] wdata,
                            input int limit, output logic acked, output logic [31:0] rdata);
        int waited;
        waited = 0;
        acked = 1'b0;
        rdata = '0;
        @(negedge clk);
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we = isWrite;
        req.adr = addr;
        req.dat = wdata;
        while (!acked && waited < limit) begin
            @(negedge clk);
            waited++;
            if (rsp.ack) begin
                acked = 1'b1;
                rdata = rsp.dat;
            end
        end
        // dat held, the write side latches it while ack is up
        req.cyc = 1'b0;
        req.stb = 1'b0;
    endtask

    task automatic readWord(input logic [1:0] addr, output logic [31:0] data);
        logic acked;
        busCycle(1'b0, addr, 32'd0, 8, acked, data);
        if (!acked) begin
            errorCount++;
            $display("read of word %0d was never acknowledged", addr);
        end
    endtask

    task automatic writeMask(input logic [15:0] mask, input int limit, output logic acked);
        logic [31:0] unused;
        busCycle(1'b1, outlierPkg::AddrStatus, {16'd0, mask}, limit, acked, unused);
    endtask

    // sixteen lfsr steps, one per mask bit
    task automatic drawMask(output logic [15:0] mask);
        for (int b = 0; b < 16; b++) begin
            lfsrState = lfsrNext(lfsrState);
            mask[b] = lfsrState[0];
        end
    endtask

    // poll status until the network has delivered
    task automatic waitForResult();
        outlierPkg::readWordU w;
        int polls;
        polls = 0;
        w = statusWord(0, 1'b0, 1'b1);
        while (w.statusView.empty && polls < 16) begin
            readWord(outlierPkg::AddrStatus, w);
            polls++;
        end
        if (w.statusView.empty) begin
            errorCount++;
            $display("result never reached the queue after %0d status polls", polls);
        end
    endtask

    task automatic runMask(input logic [15:0] mask, input outlierPkg::resultT want);
        outlierPkg::readWordU w;
        logic acked;
        writeMask(mask, 20, acked);
        if (!acked) begin
            errorCount++;
            $display("write of mask %04h was never acknowledged", mask);
        end
        waitForResult();
        readWord(outlierPkg::AddrResult, w);
        checkResult($sformatf("rsp.dat result mask %04h", mask), w.resultView.result, want);
    endtask

    initial begin
        outlierPkg::readWordU word;
        logic [15:0] mask;
        logic acked;
        logic stalled;
        int ackedCount;
        logic [15:0] pending [$];
        rstN = 1'b0;
        req = '0;
        lfsrState = 16'd35;
        // eight rising edges with reset low
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        // queue empty out of reset
        readWord(outlierPkg::AddrStatus, word);
        checkStatus("rsp.dat status after reset", word, statusWord(0, 1'b0, 1'b1));

        for (int i = 0; i < DirectedCount; i++) begin
            runMask(directed[i].mask, directed[i].want);
        end
        for (int i = 0; i < RandomCount; i++) begin
            drawMask(mask);
            runMask(mask, refResult(mask));
        end

        // no reads, credit runs out once the queue is spoken for
        stalled = 1'b0;
        ackedCount = 0;
        for (int i = 0; i < BurstCount && !stalled; i++) begin
            drawMask(mask);
            writeMask(mask, 20, acked);
            if (acked) begin
                ackedCount++;
                pending.push_back(mask);
            end else begin
                stalled = 1'b1;
            end
        end
        if (!stalled || ackedCount != QueueDepth) begin
            errorCount++;
            $display("burst gave %0d acks and stall %0b, wanted %0d acks then a stall",
                     ackedCount, stalled, QueueDepth);
        end
        readWord(outlierPkg::AddrStatus, word);
        checkStatus("rsp.dat status when full", word, statusWord(QueueDepth, 1'b1, 1'b0));

        // drain, oldest write first
        while (pending.size() > 0) begin
            mask = pending.pop_front();
            readWord(outlierPkg::AddrResult, word);
            checkResult($sformatf("rsp.dat drained mask %04h", mask), word.resultView.result,
                        refResult(mask));
        end
        readWord(outlierPkg::AddrResult, word);
        checkWord("rsp.dat read of empty queue", word, 32'd0);
        readWord(outlierPkg::AddrStatus, word);
        checkStatus("rsp.dat status after drain", word, statusWord(0, 1'b0, 1'b1));

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+bench
design/outlierPkg.sv
design/maskWriteSlave.sv
design/strideStage.sv
design/compactNet.sv
design/resultQueue.sv
design/outlierSelect.sv
bench/tbOutlierSelect.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with verilator, run, then judge the run by its log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tbOutlierSelect -f tb.f \
    -o simOutlier > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simOutlier > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log && grep -qx "Result: PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
